// ==== logic/umi_pkg.sv ====
/*
 * UMI command word layout and opcode values.
 * Only the opcode, size and len fields are decoded on the transmit side.
 * Opcodes that are not listed here are sent as packets carrying data.
 */

package umi_pkg;

   // Packet field widths
   localparam int CW = 32;                  // Command word
   localparam int AW = 64;                  // Address
   localparam int DW = 128;                 // Data payload

   // Command fields, each given as bit position and width
   localparam int OPCODE_LSB = 0;
   localparam int OPCODE_W   = 5;
   localparam int SIZE_LSB   = 5;           // log2 of word size
   localparam int SIZE_W     = 3;
   localparam int LEN_LSB    = 8;           // Words minus one
   localparam int LEN_W      = 8;

   // ##########################################################################
   // Opcodes
   // ##########################################################################
   localparam logic [OPCODE_W-1:0] OP_INVALID    = 5'd0;
   localparam logic [OPCODE_W-1:0] OP_REQ_READ   = 5'd1;
   localparam logic [OPCODE_W-1:0] OP_RESP_READ  = 5'd2;
   localparam logic [OPCODE_W-1:0] OP_REQ_WRITE  = 5'd3;
   localparam logic [OPCODE_W-1:0] OP_RESP_WRITE = 5'd4;
   localparam logic [OPCODE_W-1:0] OP_REQ_POSTED = 5'd5;
   localparam logic [OPCODE_W-1:0] OP_REQ_RDMA   = 5'd6;
   localparam logic [OPCODE_W-1:0] OP_REQ_ERROR  = 5'd8;
   localparam logic [OPCODE_W-1:0] OP_REQ_ATOMIC = 5'd9;
   localparam logic [OPCODE_W-1:0] OP_REQ_LINK   = 5'd15;

   // How much of the packet goes on the wire
   typedef enum logic [1:0] {
      CMD_ONLY,                             // Command word alone
      NO_DATA,                              // Command plus both addresses
      WITH_DATA                             // Header plus data bytes
   } len_class_t;

endpackage

// ==== logic/lumi_pkg.sv ====
/*
 * Link layer constants for the transmitter.
 * The frame is the full UMI packet, cmd in the low bytes.
 * HDR_BYTES plus DATA_BYTES has to equal FRAME_BYTES.
 */

package lumi_pkg;

   // PHY side
   localparam int IOW    = 64;              // PHY data word
   localparam int RATE_W = 2;               // csr_iowidth, 1 to 8 bytes per beat

   // Frame layout in bytes
   localparam int FRAME_BYTES = (umi_pkg::CW + 2*umi_pkg::AW + umi_pkg::DW)/8;
   localparam int CMD_BYTES   = umi_pkg::CW/8;
   localparam int HDR_BYTES   = (umi_pkg::CW + 2*umi_pkg::AW)/8;  // cmd, dstaddr, srcaddr
   localparam int DATA_BYTES  = umi_pkg::DW/8;

   // Counter widths
   localparam int CRDT_W  = 16;             // Credits are counted in beats
   localparam int BYTES_W = 12;             // Packet byte count

endpackage

// ==== logic/lumi_chan_if.sv ====
/*
 * Link between one channel gate and the serializer.
 * take and beat are single cycle strobes from the serializer.
 */

`timescale 1ns/1ps

interface lumi_chan_if import lumi_pkg::*; ();

   logic                   eligible;        // Valid and credit check passed
   logic [FRAME_BYTES-1:0] start_mask;      // Byte valid mask, cmd byte 0 at bit 0
   logic                   take;            // Packet captured this cycle
   logic                   beat;            // One beat of this channel sent

   modport gate (
      output eligible,
      output start_mask,
      input  take,
      input  beat
   );

   modport serializer (
      input  eligible,
      input  start_mask,
      output take,
      output beat
   );

endinterface

// ==== logic/lumi_chan_gate.sv ====
/*
 * Length decode and credit gate for one UMI channel.
 * Credits are counted in beats at the current csr_iowidth rate, so the
 * rate must not change while packets are in flight.
 * Data beyond DATA_BYTES is dropped by the mask but still counted in need.
 */

`timescale 1ns/1ps

module lumi_chan_gate import umi_pkg::*, lumi_pkg::*;
(
   input  logic              clk,
   input  logic              nreset,
   input  logic              csr_en,          // Link enable, clears sent count
   input  logic              csr_crdt_en,     // 0 = infinite credit
   input  logic [RATE_W-1:0] csr_iowidth,
   input  logic              in_valid,
   input  logic [CW-1:0]     in_cmd,
   input  logic [CRDT_W-1:0] rmt_crdt,        // Credits granted by remote side
   input  logic [1:0]        rmt_crdt_init,   // Remote still initialising
   output logic [15:0]       stall_count,     // Cycles blocked on credit
   lumi_chan_if.gate         chan
);

   logic [OPCODE_W-1:0]    opcode;
   logic [SIZE_W-1:0]      size;
   logic [LEN_W-1:0]       len;
   len_class_t             len_class;
   logic [BYTES_W-1:0]     data_bytes;
   logic [BYTES_W-1:0]     pkt_bytes;
   logic [DATA_BYTES-1:0]  data_mask;
   logic [FRAME_BYTES-1:0] start_mask;
   logic [BYTES_W-1:0]     pkt_lines;
   logic                   pkt_rem;
   logic [CRDT_W-1:0]      need;
   logic [CRDT_W-1:0]      avail;
   logic [CRDT_W-1:0]      sent;
   logic                   crdt_ok;

   // ##########################################################################
   // Length decode
   // ##########################################################################
   assign opcode = in_cmd[OPCODE_LSB +: OPCODE_W];
   assign size   = in_cmd[SIZE_LSB +: SIZE_W];
   assign len    = in_cmd[LEN_LSB +: LEN_W];

   always_comb
   begin
      case (opcode)
         OP_INVALID, OP_REQ_LINK:                           len_class = CMD_ONLY;
         OP_REQ_READ, OP_REQ_RDMA, OP_REQ_ERROR, OP_RESP_WRITE: len_class = NO_DATA;
         OP_RESP_READ, OP_REQ_WRITE, OP_REQ_POSTED, OP_REQ_ATOMIC:
            len_class = WITH_DATA;
         default:                                           len_class = WITH_DATA;
      endcase
   end

   // (len+1) words of 2^size bytes
   assign data_bytes = (BYTES_W'(len) + BYTES_W'(1)) << size;
   assign data_mask  = ~({DATA_BYTES{1'b1}} << data_bytes);  // All ones once >= 16

   always_comb
   begin
      case (len_class)
         CMD_ONLY:
         begin
            pkt_bytes  = BYTES_W'(CMD_BYTES);
            start_mask = FRAME_BYTES'({CMD_BYTES{1'b1}});
         end
         NO_DATA:
         begin
            pkt_bytes  = BYTES_W'(HDR_BYTES);
            start_mask = FRAME_BYTES'({HDR_BYTES{1'b1}});
         end
         default:
         begin
            pkt_bytes  = BYTES_W'(HDR_BYTES) + data_bytes;
            start_mask = {data_mask, {HDR_BYTES{1'b1}}};   // Data sits above header
         end
      endcase
   end

   assign chan.start_mask = start_mask;

   // ##########################################################################
   // Credit check
   // ##########################################################################
   // Beats needed, rounded up
   assign pkt_lines = pkt_bytes >> csr_iowidth;
   assign pkt_rem   = |(pkt_bytes & ~({BYTES_W{1'b1}} << csr_iowidth));
   assign need      = CRDT_W'(pkt_lines) + CRDT_W'(pkt_rem);

   // Beat leaving this cycle is already spent
   assign avail = rmt_crdt - sent - CRDT_W'(chan.beat);

   assign crdt_ok = !csr_crdt_en || ((rmt_crdt_init == 2'b00) && (avail >= need));

   assign chan.eligible = in_valid & crdt_ok;

   // Beats sent on this channel
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         sent <= '0;
      else if (!csr_en)
         sent <= '0;
      else if (chan.beat)
         sent <= sent + 1'b1;
   end

   // No-credit cycles, wraps at 16 bits
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         stall_count <= '0;
      else if (in_valid && !crdt_ok)
         stall_count <= stall_count + 1'b1;
   end

endmodule

// ==== logic/lumi_serializer.sv ====
/*
 * Picks one channel, captures its packet and shifts it out LSB byte first.
 * Response wins over request. A new packet is taken on the last beat.
 * phy_txdata is undefined until the first frame has been captured.
 */

`timescale 1ns/1ps

module lumi_serializer import umi_pkg::*, lumi_pkg::*;
(
   input  logic              clk,
   input  logic              nreset,
   input  logic              csr_en,
   input  logic              phy_txrdy,      // PHY accepts a word this cycle
   input  logic [RATE_W-1:0] csr_iowidth,    // log2 bytes per beat
   lumi_chan_if.serializer   req,
   lumi_chan_if.serializer   resp,
   input  logic [CW-1:0]     req_cmd,
   input  logic [CW-1:0]     resp_cmd,
   input  logic [AW-1:0]     req_dstaddr,
   input  logic [AW-1:0]     req_srcaddr,
   input  logic [AW-1:0]     resp_dstaddr,
   input  logic [AW-1:0]     resp_srcaddr,
   input  logic [DW-1:0]     req_data,
   input  logic [DW-1:0]     resp_data,
   output logic [IOW-1:0]    phy_txdata,
   output logic              phy_txvld
);

   logic [3:0]               byterate;       // 1, 2, 4 or 8
   logic [FRAME_BYTES*8-1:0] frame;
   logic [FRAME_BYTES*8-1:0] frame_in;
   logic [FRAME_BYTES-1:0]   mask;
   logic [FRAME_BYTES-1:0]   mask_in;
   logic [FRAME_BYTES-1:0]   mask_next;
   logic [1:0]               frame_type;     // {resp, req}
   logic                     idle;
   logic                     last_beat;
   logic                     capture;
   logic                     take_req;
   logic                     take_resp;
   logic                     shift_en;

   assign byterate  = 4'd1 << csr_iowidth;
   assign mask_next = mask >> byterate;

   // ##########################################################################
   // Arbitration
   // ##########################################################################
   assign idle      = ~|mask;
   assign last_beat = phy_txvld & ~|mask_next;   // Remaining bytes fit this beat

   assign capture = csr_en & phy_txrdy & (idle | last_beat) &
                    (req.eligible | resp.eligible);

   assign take_resp = capture & resp.eligible;
   assign take_req  = capture & req.eligible & ~resp.eligible;

   assign resp.take = take_resp;
   assign req.take  = take_req;

   // Winner's packet, data on top
   assign frame_in = take_resp ? {resp_data, resp_srcaddr, resp_dstaddr, resp_cmd} :
                                 {req_data, req_srcaddr, req_dstaddr, req_cmd};
   assign mask_in  = take_resp ? resp.start_mask : req.start_mask;

   // ##########################################################################
   // Shift register
   // ##########################################################################
   assign shift_en = phy_txvld & phy_txrdy;

   // Beats are charged to the frame currently on the wire
   assign req.beat  = shift_en & frame_type[0];
   assign resp.beat = shift_en & frame_type[1];

   always_ff @(posedge clk)
   begin
      if (capture)
         frame <= frame_in;
      else if (shift_en)
         frame <= frame >> {byterate, 3'b000};    // Bytes to bits
   end

   // Mask only empties by shifting out
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         mask <= '0;
      else if (capture)
         mask <= mask_in;
      else if (phy_txrdy)
         mask <= mask_next;
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         frame_type <= 2'b00;
      else if (capture)
         frame_type <= {take_resp, take_req};
   end

   // Data and valid hold while phy_txrdy is low
   assign phy_txdata = frame[IOW-1:0];
   assign phy_txvld  = |mask;

endmodule

// ==== logic/lumi_tx.sv ====
/*
 * LUMI link transmitter, two UMI channels onto one PHY word.
 * Single clock. phy_txrdy comes straight from the PHY.
 * ready outputs are combinational from valid and the credit state.
 */

`timescale 1ns/1ps

module lumi_tx import umi_pkg::*, lumi_pkg::*;
(
   input  logic              clk,
   input  logic              nreset,
   // Control
   input  logic              csr_en,             // 1 = link enabled
   input  logic              csr_crdt_en,        // 1 = honour remote credits
   input  logic [RATE_W-1:0] csr_iowidth,        // log2 bytes per beat
   // Request channel
   input  logic              umi_req_in_valid,
   input  logic [CW-1:0]     umi_req_in_cmd,
   input  logic [AW-1:0]     umi_req_in_dstaddr,
   input  logic [AW-1:0]     umi_req_in_srcaddr,
   input  logic [DW-1:0]     umi_req_in_data,
   output logic              umi_req_in_ready,
   // Response channel
   input  logic              umi_resp_in_valid,
   input  logic [CW-1:0]     umi_resp_in_cmd,
   input  logic [AW-1:0]     umi_resp_in_dstaddr,
   input  logic [AW-1:0]     umi_resp_in_srcaddr,
   input  logic [DW-1:0]     umi_resp_in_data,
   output logic              umi_resp_in_ready,
   // Credits from the remote receiver
   input  logic [CRDT_W-1:0] rmt_crdt_req,
   input  logic [CRDT_W-1:0] rmt_crdt_resp,
   input  logic [1:0]        rmt_crdt_init,
   output logic [31:0]       csr_crdt_status,    // {resp stalls, req stalls}
   // PHY
   input  logic              phy_txrdy,
   output logic [IOW-1:0]    phy_txdata,
   output logic              phy_txvld
);

   logic [15:0] req_stall;
   logic [15:0] resp_stall;

   lumi_chan_if req_if ();
   lumi_chan_if resp_if ();

   // ##########################################################################
   // Channel gates
   // ##########################################################################
   lumi_chan_gate gate_req (
      .clk           (clk),
      .nreset        (nreset),
      .csr_en        (csr_en),
      .csr_crdt_en   (csr_crdt_en),
      .csr_iowidth   (csr_iowidth),
      .in_valid      (umi_req_in_valid),
      .in_cmd        (umi_req_in_cmd),
      .rmt_crdt      (rmt_crdt_req),
      .rmt_crdt_init (rmt_crdt_init),
      .stall_count   (req_stall),
      .chan          (req_if.gate)
   );

   lumi_chan_gate gate_resp (
      .clk           (clk),
      .nreset        (nreset),
      .csr_en        (csr_en),
      .csr_crdt_en   (csr_crdt_en),
      .csr_iowidth   (csr_iowidth),
      .in_valid      (umi_resp_in_valid),
      .in_cmd        (umi_resp_in_cmd),
      .rmt_crdt      (rmt_crdt_resp),
      .rmt_crdt_init (rmt_crdt_init),
      .stall_count   (resp_stall),
      .chan          (resp_if.gate)
   );

   // ##########################################################################
   // Serializer
   // ##########################################################################
   lumi_serializer ser0 (
      .clk          (clk),
      .nreset       (nreset),
      .csr_en       (csr_en),
      .phy_txrdy    (phy_txrdy),
      .csr_iowidth  (csr_iowidth),
      .req          (req_if.serializer),
      .resp         (resp_if.serializer),
      .req_cmd      (umi_req_in_cmd),
      .resp_cmd     (umi_resp_in_cmd),
      .req_dstaddr  (umi_req_in_dstaddr),
      .req_srcaddr  (umi_req_in_srcaddr),
      .resp_dstaddr (umi_resp_in_dstaddr),
      .resp_srcaddr (umi_resp_in_srcaddr),
      .req_data     (umi_req_in_data),
      .resp_data    (umi_resp_in_data),
      .phy_txdata   (phy_txdata),
      .phy_txvld    (phy_txvld)
   );

   // UMI transfer happens on the capture pulse
   assign umi_req_in_ready  = req_if.take;
   assign umi_resp_in_ready = resp_if.take;

   assign csr_crdt_status = {resp_stall, req_stall};

endmodule

// ==== bench/lumi_tx_tb.sv ====
/*
 * Table driven testbench for lumi_tx with one row per test.
 * Expected bytes come from a model of the UMI length and credit rules.
 * Pad bytes after a packet's end in its last beat are not compared.
 */

`timescale 1ns/1ps

module lumi_tx_tb import umi_pkg::*, lumi_pkg::*;
();

   logic              clk;
   logic              nreset;
   logic              csr_en;
   logic              csr_crdt_en;
   logic [RATE_W-1:0] csr_iowidth;
   logic              umi_req_in_valid;
   logic [CW-1:0]     umi_req_in_cmd;
   logic [AW-1:0]     umi_req_in_dstaddr;
   logic [AW-1:0]     umi_req_in_srcaddr;
   logic [DW-1:0]     umi_req_in_data;
   logic              umi_req_in_ready;
   logic              umi_resp_in_valid;
   logic [CW-1:0]     umi_resp_in_cmd;
   logic [AW-1:0]     umi_resp_in_dstaddr;
   logic [AW-1:0]     umi_resp_in_srcaddr;
   logic [DW-1:0]     umi_resp_in_data;
   logic              umi_resp_in_ready;
   logic [CRDT_W-1:0] rmt_crdt_req;
   logic [CRDT_W-1:0] rmt_crdt_resp;
   logic [1:0]        rmt_crdt_init;
   logic [31:0]       csr_crdt_status;
   logic              phy_txrdy;
   logic [IOW-1:0]    phy_txdata;
   logic              phy_txvld;

   integer     seed;
   int         errors;
   int         failed_tests;
   logic [7:0] rdy_pat;                   // phy_txrdy pattern with one bit per cycle
   logic [2:0] pat_idx;
   logic       took_prev;                 // Ready pulse seen at the last falling edge
   int         req_takes;                 // Ready pulses seen this test
   int         resp_takes;
   int         got_beats;
   int         exp_beats;
   logic [7:0] got_bytes [$];
   logic [7:0] exp_bytes [$];
   logic       exp_care [$];              // 0 for pad bytes

   // Stimulus table with one queue per column
   logic [1:0]        t_chans [$];        // {resp, req} driven
   logic [CW-1:0]     t_cmd_req [$];
   logic [CW-1:0]     t_cmd_resp [$];
   logic [RATE_W-1:0] t_rate [$];
   logic [CRDT_W-1:0] t_crdt [$];         // Credit at start
   logic [CRDT_W-1:0] t_crdt_rel [$];     // Credit after the hold
   logic [1:0]        t_init [$];
   logic              t_crdt_en [$];
   logic              t_en [$];
   int                t_hold [$];         // Cycles held blocked
   logic [7:0]        t_pat [$];
   logic              t_take [$];         // Packets expected on the wire
   int                t_stall [$];        // Stall increase per driven channel

   lumi_tx dut0 (.*);

   always #20 clk = ~clk;

   // PHY back-pressure
   always @(posedge clk)
   begin
      if (nreset)
      begin
         phy_txrdy <= rdy_pat[pat_idx];
         pat_idx   <= pat_idx + 1'b1;
      end
   end

   // ##########################################################################
   // Monitor sampled mid cycle
   // ##########################################################################
   always @(negedge clk)
   begin : monitor
      int k;
      if (nreset && took_prev)
         check("phy_txvld after ready", phy_txvld, 1);   // Capture takes one cycle
      took_prev = nreset && (umi_req_in_ready || umi_resp_in_ready);
      if (nreset && umi_req_in_ready)
         req_takes++;
      if (nreset && umi_resp_in_ready)
         resp_takes++;
      if (nreset && phy_txvld && phy_txrdy)
      begin
         got_beats++;
         for (k = 0; k < (1 << csr_iowidth); k++)
            got_bytes.push_back(phy_txdata[8*k +: 8]);   // LSB byte first
      end
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   function automatic logic [CW-1:0] umi_cmd(input logic [OPCODE_W-1:0] op, input int size,
                                              input int len);
      umi_cmd                        = {16'h3c5a, 16'h0000};  // Upper bits just ride along
      umi_cmd[OPCODE_LSB +: OPCODE_W] = op;
      umi_cmd[SIZE_LSB +: SIZE_W]     = size[SIZE_W-1:0];
      umi_cmd[LEN_LSB +: LEN_W]       = len[LEN_W-1:0];
   endfunction

   function automatic len_class_t class_of(input logic [CW-1:0] cmd);
      case (cmd[OPCODE_LSB +: OPCODE_W])
         OP_INVALID, OP_REQ_LINK:                               class_of = CMD_ONLY;
         OP_REQ_READ, OP_REQ_RDMA, OP_REQ_ERROR, OP_RESP_WRITE: class_of = NO_DATA;
         default:                                               class_of = WITH_DATA;
      endcase
   endfunction

   // Reference model appends one packet to the expected stream
   task automatic expect_packet(input logic [CW-1:0] cmd, input logic [AW-1:0] dst,
                                input logic [AW-1:0] src, input logic [DW-1:0] data,
                                input int rb);
      logic [FRAME_BYTES*8-1:0] frame;
      int n;
      int dbytes;
      int beats;
      int k;
      frame  = {data, src, dst, cmd};
      dbytes = (int'(cmd[LEN_LSB +: LEN_W]) + 1) << cmd[SIZE_LSB +: SIZE_W];
      case (class_of(cmd))
         CMD_ONLY: n = CMD_BYTES;
         NO_DATA:  n = HDR_BYTES;
         default:  n = HDR_BYTES + ((dbytes > DATA_BYTES) ? DATA_BYTES : dbytes);
      endcase
      beats     = (n + rb - 1) / rb;            // Rounded up
      exp_beats = exp_beats + beats;
      for (k = 0; k < beats * rb; k++)
      begin
         exp_bytes.push_back((k < FRAME_BYTES) ? frame[8*k +: 8] : 8'h00);
         exp_care.push_back(k < n);
      end
   endtask

   task automatic add_row(input logic [1:0] chans, input logic [CW-1:0] cmd_req,
                          input logic [CW-1:0] cmd_resp, input int rate, input int crdt,
                          input int crdt_rel, input int init, input bit crdt_en,
                          input bit en, input int hold, input logic [7:0] pat,
                          input bit take, input int stall);
      t_chans.push_back(chans);
      t_cmd_req.push_back(cmd_req);
      t_cmd_resp.push_back(cmd_resp);
      t_rate.push_back(rate[RATE_W-1:0]);
      t_crdt.push_back(crdt[CRDT_W-1:0]);
      t_crdt_rel.push_back(crdt_rel[CRDT_W-1:0]);
      t_init.push_back(init[1:0]);
      t_crdt_en.push_back(crdt_en);
      t_en.push_back(en);
      t_hold.push_back(hold);
      t_pat.push_back(pat);
      t_take.push_back(take);
      t_stall.push_back(stall);
   endtask

   // ##########################################################################
   // Stimulus table
   // ##########################################################################
   task automatic build_table();
      // Length classes at each rate
      add_row(2'b01, umi_cmd(OP_REQ_READ, 0, 0), 0, 0, 0, 0, 0, 0, 1, 0, 8'hff, 1, 0);
      add_row(2'b01, umi_cmd(OP_REQ_LINK, 0, 0), 0, 0, 0, 0, 0, 0, 1, 0, 8'hff, 1, 0);
      add_row(2'b01, umi_cmd(OP_REQ_WRITE, 2, 3), 0, 0, 0, 0, 0, 0, 1, 0, 8'hff, 1, 0);
      add_row(2'b10, 0, umi_cmd(OP_REQ_LINK, 0, 0), 1, 0, 0, 0, 0, 1, 0, 8'hff, 1, 0);
      add_row(2'b01, umi_cmd(OP_REQ_READ, 0, 0), 0, 1, 0, 0, 0, 0, 1, 0, 8'hff, 1, 0);
      add_row(2'b01, umi_cmd(OP_REQ_WRITE, 1, 2), 0, 1, 0, 0, 0, 0, 1, 0, 8'hff, 1, 0);
      add_row(2'b10, 0, umi_cmd(OP_REQ_READ, 0, 0), 2, 0, 0, 0, 0, 1, 0, 8'hff, 1, 0);
      add_row(2'b01, umi_cmd(OP_REQ_LINK, 0, 0), 0, 2, 0, 0, 0, 0, 1, 0, 8'hff, 1, 0);
      add_row(2'b01, umi_cmd(OP_REQ_POSTED, 0, 5), 0, 2, 0, 0, 0, 0, 1, 0, 8'hff, 1, 0);
      add_row(2'b01, umi_cmd(OP_REQ_RDMA, 0, 0), 0, 3, 0, 0, 0, 0, 1, 0, 8'hff, 1, 0);
      add_row(2'b01, umi_cmd(OP_INVALID, 0, 0), 0, 3, 0, 0, 0, 0, 1, 0, 8'hff, 1, 0);
      add_row(2'b10, 0, umi_cmd(OP_REQ_WRITE, 3, 1), 3, 0, 0, 0, 0, 1, 0, 8'hff, 1, 0);
      // Both valid at once so the response goes first
      add_row(2'b11, umi_cmd(OP_REQ_ATOMIC, 0, 7), umi_cmd(OP_RESP_READ, 2, 0), 2,
              0, 0, 0, 0, 1, 0, 8'hff, 1, 0);
      // 26 bytes at 2 per beat needs 13 credits
      add_row(2'b01, umi_cmd(OP_REQ_WRITE, 0, 5), 0, 1, 12, 13, 0, 1, 1, 5, 8'hff, 1, 5);
      // Remote init pending blocks both
      add_row(2'b11, umi_cmd(OP_REQ_POSTED, 2, 3), umi_cmd(OP_RESP_WRITE, 0, 0), 3,
              100, 100, 2, 1, 1, 4, 8'hff, 1, 4);
      // PHY stalls mid frame
      add_row(2'b01, umi_cmd(OP_REQ_WRITE, 3, 1), 0, 1, 0, 0, 0, 0, 1, 0, 8'b1011_0010, 1, 0);
      add_row(2'b11, umi_cmd(OP_REQ_LINK, 0, 0), umi_cmd(OP_RESP_READ, 3, 0), 3,
              0, 0, 0, 0, 1, 0, 8'b0110_1101, 1, 0);
      // Link disabled
      add_row(2'b11, umi_cmd(OP_REQ_READ, 0, 0), umi_cmd(OP_RESP_WRITE, 0, 0), 2,
              0, 0, 0, 0, 0, 6, 8'hff, 0, 0);
   endtask

   task automatic run_test(input int t);
      logic [AW-1:0] req_dst;
      logic [AW-1:0] req_src;
      logic [DW-1:0] req_dat;
      logic [AW-1:0] resp_dst;
      logic [AW-1:0] resp_src;
      logic [DW-1:0] resp_dat;
      logic [1:0]    pending;
      logic [31:0]   st0;
      logic [31:0]   st1;
      logic [15:0]   req_stalls;
      logic [15:0]   resp_stalls;
      int            rb;
      int            errs0;
      int            k;
      errs0    = errors;
      rb       = 1 << t_rate[t];
      req_dst  = {$random(seed), $random(seed)};
      req_src  = {$random(seed), $random(seed)};
      req_dat  = {$random(seed), $random(seed), $random(seed), $random(seed)};
      resp_dst = {$random(seed), $random(seed)};
      resp_src = {$random(seed), $random(seed)};
      resp_dat = {$random(seed), $random(seed), $random(seed), $random(seed)};

      // Link off for one edge clears the sent counts
      @(posedge clk);
      csr_en              <= 1'b0;
      csr_iowidth         <= t_rate[t];
      csr_crdt_en         <= t_crdt_en[t];
      rmt_crdt_req        <= t_crdt[t];
      rmt_crdt_resp       <= t_crdt[t];
      rmt_crdt_init       <= t_init[t];
      rdy_pat             <= t_pat[t];
      umi_req_in_cmd      <= t_cmd_req[t];
      umi_req_in_dstaddr  <= req_dst;
      umi_req_in_srcaddr  <= req_src;
      umi_req_in_data     <= req_dat;
      umi_resp_in_cmd     <= t_cmd_resp[t];
      umi_resp_in_dstaddr <= resp_dst;
      umi_resp_in_srcaddr <= resp_src;
      umi_resp_in_data    <= resp_dat;
      req_takes  = 0;
      resp_takes = 0;
      got_beats  = 0;
      exp_beats  = 0;
      got_bytes.delete();
      exp_bytes.delete();
      exp_care.delete();
      // Response goes on the wire first
      if (t_take[t] && t_chans[t][1])
         expect_packet(t_cmd_resp[t], resp_dst, resp_src, resp_dat, rb);
      if (t_take[t] && t_chans[t][0])
         expect_packet(t_cmd_req[t], req_dst, req_src, req_dat, rb);
      @(posedge clk);
      @(negedge clk);
      st0 = csr_crdt_status;

      @(posedge clk);
      csr_en            <= t_en[t];
      umi_req_in_valid  <= t_chans[t][0];
      umi_resp_in_valid <= t_chans[t][1];
      pending = t_chans[t];
      if (t_hold[t] > 0)
      begin
         repeat (t_hold[t]) @(posedge clk);
         check("ready pulses while blocked", req_takes + resp_takes, 0);
         if (t_en[t])
         begin
            rmt_crdt_req  <= t_crdt_rel[t];     // Release credit and init
            rmt_crdt_resp <= t_crdt_rel[t];
            rmt_crdt_init <= 2'b00;
         end
         else
         begin
            umi_req_in_valid  <= 1'b0;
            umi_resp_in_valid <= 1'b0;
            pending = 2'b00;
         end
      end

      // Valid drops on the edge that takes the packet
      while (pending != 2'b00)
      begin
         @(posedge clk);
         if (pending[0] && req_takes != 0)
         begin
            umi_req_in_valid <= 1'b0;
            pending[0] = 1'b0;
         end
         if (pending[1] && resp_takes != 0)
         begin
            umi_resp_in_valid <= 1'b0;
            pending[1] = 1'b0;
         end
      end
      do
         @(negedge clk);
      while (got_bytes.size() < exp_bytes.size() || phy_txvld);
      st1 = csr_crdt_status;

      check("umi_req_in_ready pulses", req_takes, t_chans[t][0] & t_take[t]);
      check("umi_resp_in_ready pulses", resp_takes, t_chans[t][1] & t_take[t]);
      check("phy_txvld beats", got_beats, exp_beats);
      check("phy_txdata byte count", got_bytes.size(), exp_bytes.size());
      for (k = 0; k < exp_bytes.size(); k++)
      begin
         if (exp_care[k] && k < got_bytes.size())
            check($sformatf("phy_txdata byte %0d", k), got_bytes[k], exp_bytes[k]);
      end
      req_stalls  = st1[15:0] - st0[15:0];
      resp_stalls = st1[31:16] - st0[31:16];
      check("csr_crdt_status[15:0] increase", req_stalls, t_chans[t][0] ? t_stall[t] : 0);
      check("csr_crdt_status[31:16] increase", resp_stalls, t_chans[t][1] ? t_stall[t] : 0);
      if (errors != errs0)
         failed_tests++;
      $display("test %0d: rate %0d, chans %b, %0d beats, %0d mismatches", t, rb, t_chans[t],
               got_beats, errors - errs0);
   endtask

   // ##########################################################################
   // Main sequence
   // ##########################################################################
   initial
   begin
      int t;
      seed                = 32'hb36d;
      errors              = 0;
      failed_tests        = 0;
      rdy_pat             = 8'hff;
      pat_idx             = 3'd0;
      took_prev           = 1'b0;
      clk                 = 1'b0;
      nreset              = 1'b0;
      csr_en              = 1'b0;
      csr_crdt_en         = 1'b0;
      csr_iowidth         = '0;
      umi_req_in_valid    = 1'b0;
      umi_req_in_cmd      = '0;
      umi_req_in_dstaddr  = '0;
      umi_req_in_srcaddr  = '0;
      umi_req_in_data     = '0;
      umi_resp_in_valid   = 1'b0;
      umi_resp_in_cmd     = '0;
      umi_resp_in_dstaddr = '0;
      umi_resp_in_srcaddr = '0;
      umi_resp_in_data    = '0;
      rmt_crdt_req        = '0;
      rmt_crdt_resp       = '0;
      rmt_crdt_init       = 2'b00;
      phy_txrdy           = 1'b1;
      build_table();
      repeat (4) @(posedge clk);
      nreset <= 1'b1;
      // Counters and valid come out of reset low
      @(negedge clk);
      check("csr_crdt_status after reset", csr_crdt_status, 0);
      check("phy_txvld after reset", phy_txvld, 0);
      for (t = 0; t < t_chans.size(); t++)
         run_test(t);
      $display("%0d tests run, %0d failed, %0d mismatches", t_chans.size(), failed_tests,
               errors);
      if (errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

   // Budget is a full rate 0 frame plus slack per row
   initial
   begin : watchdog
      longint limit_ns;
      #1;
      limit_ns = longint'(t_chans.size()) * (FRAME_BYTES + 20) * 40;
      #(limit_ns);
      $display("Timeout: the tests did not finish within %0d ns, the run hung", limit_ns);
      $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== lumi_tx.f ====
logic/umi_pkg.sv
logic/lumi_pkg.sv
logic/lumi_chan_if.sv
logic/lumi_chan_gate.sv
logic/lumi_serializer.sv
logic/lumi_tx.sv
bench/lumi_tx_tb.sv

// ==== Bender.yml ====
package:
  name: lumi_tx

sources:
  # Packages first, then the interface and the RTL
  - logic/umi_pkg.sv
  - logic/lumi_pkg.sv
  - logic/lumi_chan_if.sv
  - logic/lumi_chan_gate.sv
  - logic/lumi_serializer.sv
  - logic/lumi_tx.sv
  - target: test
    files:
      - bench/lumi_tx_tb.sv
